// File: source/pkt_filter_pkg.sv
// Rx frame filter definitions
package pkt_filter_pkg;

    typedef logic [47:0] mac_addr_t;     // first octet in bits 7:0
    typedef logic [15:0] sig_len_t;
    typedef logic [1:0]  fc_type_t;
    typedef logic [3:0]  fc_subtype_t;
    typedef logic [1:0]  tofrom_ds_t;
    typedef logic [13:0] filter_flags_t;
    typedef logic [8:0]  discard_mask_t;
    typedef logic [2:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    typedef enum logic [3:0] {
        kind_beacon, kind_probe_req, kind_probe_resp,
        kind_ctrl_wrapper, kind_blkack_req, kind_blkack, kind_pspoll, kind_rts,
        kind_ack, kind_cf_end, kind_cf_end_ack,
        kind_ctrl_other, kind_other
    } frame_kind_t;

    // bits 0..8 follow ieee80211_filter_flags
    localparam int flag_allmulti    = 1;
    localparam int flag_bcn_prbresp = 4;
    localparam int flag_control     = 5;
    localparam int flag_other_bss   = 6;
    localparam int flag_pspoll      = 7;
    localparam int flag_probe_req   = 8;
    localparam int flag_unicast     = 9;
    localparam int flag_bcast_ones  = 10;
    localparam int flag_bcast_zeros = 11;
    localparam int flag_my_beacon   = 12;
    localparam int flag_monitor_all = 13;

    // minimum length needed to carry each address
    localparam sig_len_t min_len_addr1 = 16'd14;
    localparam sig_len_t min_len_addr2 = 16'd20;
    localparam sig_len_t min_len_addr3 = 16'd26;

    localparam cfg_addr_t reg_filter_cfg   = 3'd0;
    localparam cfg_addr_t reg_discard_mask = 3'd1;
    localparam cfg_addr_t reg_max_len      = 3'd2;
    localparam cfg_addr_t reg_mac_lo       = 3'd3;
    localparam cfg_addr_t reg_mac_hi       = 3'd4;
    localparam cfg_addr_t reg_bssid_lo     = 3'd5;
    localparam cfg_addr_t reg_bssid_hi     = 3'd6;

    function automatic frame_kind_t classify_frame(input fc_type_t    fc_type,
                                                   input fc_subtype_t fc_subtype);
        frame_kind_t kind;
        kind = kind_other;
        if (fc_type == 2'd0)
        begin
            case (fc_subtype)
                4'd8:    kind = kind_beacon;
                4'd4:    kind = kind_probe_req;
                4'd5:    kind = kind_probe_resp;
                default: kind = kind_other;
            endcase
        end
        else if (fc_type == 2'd1)
        begin
            case (fc_subtype)
                4'd7:    kind = kind_ctrl_wrapper;
                4'd8:    kind = kind_blkack_req;
                4'd9:    kind = kind_blkack;
                4'd10:   kind = kind_pspoll;
                4'd11:   kind = kind_rts;
                4'd13:   kind = kind_ack;
                4'd14:   kind = kind_cf_end;
                4'd15:   kind = kind_cf_end_ack;
                default: kind = kind_ctrl_other;
            endcase
        end
        return kind;
    endfunction

endpackage

// File: source/filter_cfg_if.sv
// Filter configuration bus
`timescale 1ns/1ps

interface filter_cfg_if;
    import pkt_filter_pkg::*;

    filter_flags_t filter_cfg;
    discard_mask_t discard_mask;
    sig_len_t      max_len;      // longest frame still treated as normal
    mac_addr_t     self_mac;
    mac_addr_t     self_bssid;

    modport regs
    (
        output filter_cfg, discard_mask, max_len, self_mac, self_bssid
    );

    modport user
    (
        input filter_cfg, discard_mask, max_len, self_mac, self_bssid
    );

endinterface

// File: source/frame_info_if.sv
// Header tracker results
`timescale 1ns/1ps

interface frame_info_if;
    import pkt_filter_pkg::*;

    logic        evaluate;     // all needed addresses seen
    logic        abnormal;     // length check failed
    logic        start;        // new frame accepted
    frame_kind_t kind;
    mac_addr_t   addr1;
    mac_addr_t   bssid;
    logic        bssid_valid;

    modport tracker
    (
        output evaluate, abnormal, start, kind, addr1, bssid, bssid_valid
    );

    modport rules
    (
        input evaluate, abnormal, start, kind, addr1, bssid, bssid_valid
    );

endinterface

// File: source/filter_cfg_regs.sv
// Filter configuration registers
`timescale 1ns/1ps

module filter_cfg_regs
#(
    parameter pkt_filter_pkg::sig_len_t max_len_reset = 16'd1600
)
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cfg_req,
    input  pkt_filter_pkg::cfg_addr_t cfg_addr,
    input  pkt_filter_pkg::cfg_data_t cfg_wdata,
    output logic                      cfg_ack,
    filter_cfg_if.regs                cfg
);
    import pkt_filter_pkg::*;

    logic wr_en;

    // a write happens once per req, on the first cycle it is seen
    assign wr_en = cfg_req && !cfg_ack;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            cfg_ack <= 1'b0;
        end
        else if (wr_en)
        begin
            cfg_ack <= 1'b1;
        end
        else if (!cfg_req && cfg_ack)
        begin
            cfg_ack <= 1'b0;     // host has released req
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            cfg.filter_cfg   <= '0;
            cfg.discard_mask <= '0;
            cfg.max_len      <= max_len_reset;
            cfg.self_mac     <= '0;
            cfg.self_bssid   <= '0;
        end
        else if (wr_en)
        begin
            case (cfg_addr)
                reg_filter_cfg:   cfg.filter_cfg         <= cfg_wdata[13:0];
                reg_discard_mask: cfg.discard_mask       <= cfg_wdata[8:0];
                reg_max_len:      cfg.max_len            <= cfg_wdata[15:0];
                reg_mac_lo:       cfg.self_mac[31:0]     <= cfg_wdata;
                reg_mac_hi:       cfg.self_mac[47:32]    <= cfg_wdata[15:0];
                reg_bssid_lo:     cfg.self_bssid[31:0]   <= cfg_wdata;
                reg_bssid_hi:     cfg.self_bssid[47:32]  <= cfg_wdata[15:0];
                default:
                begin
                    // unmapped, acked and dropped
                end
            endcase
        end
    end

endmodule

// File: source/header_tracker.sv
// Rx header stage tracker
`timescale 1ns/1ps

module header_tracker
(
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        sig_valid,
    input  pkt_filter_pkg::sig_len_t    signal_len,
    input  logic                        ht_unsupport,
    input  pkt_filter_pkg::fc_type_t    fc_type,
    input  pkt_filter_pkg::fc_subtype_t fc_subtype,
    input  pkt_filter_pkg::tofrom_ds_t  fc_tofrom_ds,
    input  pkt_filter_pkg::mac_addr_t   addr1,
    input  logic                        addr1_valid,
    input  pkt_filter_pkg::mac_addr_t   addr2,
    input  logic                        addr2_valid,
    input  pkt_filter_pkg::mac_addr_t   addr3,
    input  logic                        addr3_valid,
    filter_cfg_if.user                  cfg,
    frame_info_if.tracker               info
);
    import pkt_filter_pkg::*;

    typedef enum logic [2:0] {
        idle, wait_addr1, wait_addr2, wait_addr3, action, abnormal
    } state_t;

    state_t      state;
    sig_len_t    frame_len;
    frame_kind_t kind;
    logic        accept;
    logic        bssid_load;
    mac_addr_t   bssid_src;

    assign kind   = classify_frame(fc_type, fc_subtype);
    assign accept = (state == idle) && sig_valid && !ht_unsupport;

    assign info.kind     = kind;
    assign info.evaluate = (state == action);
    assign info.abnormal = (state == abnormal);

    // bssid position depends on the to/from ds bits
    always_comb
    begin
        bssid_load = 1'b0;
        bssid_src  = addr1;
        case (state)
            wait_addr1: bssid_load = addr1_valid && (fc_tofrom_ds == 2'b10);
            wait_addr2:
            begin
                bssid_load = addr2_valid && (fc_tofrom_ds == 2'b01);
                bssid_src  = addr2;
            end
            wait_addr3:
            begin
                bssid_load = addr3_valid && (fc_tofrom_ds == 2'b00);
                bssid_src  = addr3;
            end
            default: bssid_load = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state            <= idle;
            info.start       <= 1'b0;
            info.bssid_valid <= 1'b0;
        end
        else
        begin
            info.start <= accept;
            if (bssid_load)
                info.bssid_valid <= 1'b1;   // kept across frames
            case (state)
                idle:
                begin
                    if (accept)
                    begin
                        if (signal_len >= min_len_addr1 && signal_len <= cfg.max_len)
                            state <= wait_addr1;
                        else
                            state <= abnormal;
                    end
                end
                wait_addr1:
                begin
                    if (addr1_valid)
                    begin
                        if (kind == kind_ctrl_wrapper || kind == kind_ack)
                            state <= action;    // single address frames
                        else if (frame_len >= min_len_addr2)
                            state <= wait_addr2;
                        else
                            state <= abnormal;
                    end
                end
                wait_addr2:
                begin
                    if (addr2_valid)
                    begin
                        if (kind inside {kind_rts, kind_pspoll, kind_cf_end, kind_cf_end_ack,
                                         kind_blkack_req, kind_blkack})
                            state <= action;
                        else if (frame_len >= min_len_addr3)
                            state <= wait_addr3;
                        else
                            state <= abnormal;
                    end
                end
                wait_addr3:
                begin
                    if (addr3_valid)
                        state <= action;
                end
                default: state <= idle;     // action and abnormal last one cycle
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            frame_len <= signal_len;
        if (state == wait_addr1 && addr1_valid)
            info.addr1 <= addr1;
        if (bssid_load)
            info.bssid <= bssid_src;
    end

endmodule

// File: source/filter_rules.sv
// Rx filter rule evaluation
`timescale 1ns/1ps

module filter_rules
(
    input  logic        clk,
    input  logic        rstn,
    filter_cfg_if.user  cfg,
    frame_info_if.rules info,
    output logic        block_rx_dma,
    output logic        block_valid
);
    import pkt_filter_pkg::*;

    filter_flags_t allow;
    filter_flags_t hit;
    discard_mask_t discard;
    discard_mask_t miss;
    logic          is_mcast;
    logic          ctrl_no_pspoll;
    logic          for_us;
    logic          other_bss;
    logic          my_bss;

    // 01:00:5e:xx:xx:xx or 33:33:xx:xx:xx:xx, first octet in bits 7:0
    assign is_mcast = (info.addr1[23:0] == 24'h5e0001) || (info.addr1[15:0] == 16'h3333);

    assign ctrl_no_pspoll = info.kind inside {kind_ctrl_wrapper, kind_blkack_req, kind_blkack,
                                              kind_rts, kind_ack, kind_cf_end,
                                              kind_cf_end_ack, kind_ctrl_other};

    assign for_us    = (info.addr1 == cfg.self_mac);
    assign other_bss = info.bssid_valid && (info.bssid != cfg.self_bssid);
    assign my_bss    = info.bssid_valid && (info.bssid == cfg.self_bssid);

    // hit: frame matches a rule, kept when its flag is on
    // miss: frame matches a rule whose flag is off
    always_comb
    begin
        hit                   = '0;
        hit[flag_allmulti]    = is_mcast;
        hit[flag_bcn_prbresp] = (info.kind == kind_beacon) || (info.kind == kind_probe_resp);
        hit[flag_control]     = ctrl_no_pspoll && for_us;
        hit[flag_other_bss]   = other_bss;
        hit[flag_pspoll]      = (info.kind == kind_pspoll);
        hit[flag_probe_req]   = (info.kind == kind_probe_req);
        hit[flag_unicast]     = for_us;
        hit[flag_bcast_ones]  = &info.addr1;
        hit[flag_bcast_zeros] = ~|info.addr1;
        hit[flag_my_beacon]   = my_bss && (info.kind == kind_beacon);
        hit[flag_monitor_all] = 1'b1;

        miss                   = '0;
        miss[flag_allmulti]    = is_mcast;
        miss[flag_bcn_prbresp] = hit[flag_bcn_prbresp] && other_bss;
        miss[flag_control]     = ctrl_no_pspoll;    // no address test here
        miss[flag_other_bss]   = other_bss;
        miss[flag_pspoll]      = hit[flag_pspoll];
        miss[flag_probe_req]   = hit[flag_probe_req];
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            allow       <= '0;
            discard     <= '0;
            block_valid <= 1'b0;
        end
        else
        begin
            block_valid <= info.evaluate || info.abnormal;
            if (info.abnormal)
            begin
                allow   <= '0;
                discard <= '1;
            end
            else if (info.start)
            begin
                allow   <= '0;
                discard <= '0;
            end
            else if (info.evaluate)
            begin
                allow   <= allow | (hit & cfg.filter_cfg);
                discard <= discard | (miss & ~cfg.filter_cfg[8:0]);
            end
        end
    end

    // monitor-all overrides everything, including abnormal frames
    assign block_rx_dma = !cfg.filter_cfg[flag_monitor_all] &&
                          ((allow == '0) || |(discard & cfg.discard_mask));

endmodule

// File: source/pkt_filter.sv
// Rx frame filter top
`timescale 1ns/1ps

module pkt_filter
#(
    parameter pkt_filter_pkg::sig_len_t max_len_reset = 16'd1600
)
(
    input  logic                        clk,
    input  logic                        rstn,

    // configuration write port, four-phase req/ack
    input  logic                        cfg_req,
    input  pkt_filter_pkg::cfg_addr_t   cfg_addr,
    input  pkt_filter_pkg::cfg_data_t   cfg_wdata,
    output logic                        cfg_ack,

    // header fields from the rx path
    input  logic                        sig_valid,
    input  pkt_filter_pkg::sig_len_t    signal_len,
    input  logic                        ht_unsupport,
    input  pkt_filter_pkg::fc_type_t    fc_type,
    input  pkt_filter_pkg::fc_subtype_t fc_subtype,
    input  pkt_filter_pkg::tofrom_ds_t  fc_tofrom_ds,
    input  pkt_filter_pkg::mac_addr_t   addr1,
    input  logic                        addr1_valid,
    input  pkt_filter_pkg::mac_addr_t   addr2,
    input  logic                        addr2_valid,
    input  pkt_filter_pkg::mac_addr_t   addr3,
    input  logic                        addr3_valid,

    output logic                        block_rx_dma,
    output logic                        block_valid
);

    filter_cfg_if cfg_bus ();
    frame_info_if info_bus ();

    filter_cfg_regs #(
        .max_len_reset (max_len_reset)
    ) i_filter_cfg_regs (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_req   (cfg_req),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .cfg       (cfg_bus.regs)
    );

    header_tracker i_header_tracker (
        .clk          (clk),
        .rstn         (rstn),
        .sig_valid    (sig_valid),
        .signal_len   (signal_len),
        .ht_unsupport (ht_unsupport),
        .fc_type      (fc_type),
        .fc_subtype   (fc_subtype),
        .fc_tofrom_ds (fc_tofrom_ds),
        .addr1        (addr1),
        .addr1_valid  (addr1_valid),
        .addr2        (addr2),
        .addr2_valid  (addr2_valid),
        .addr3        (addr3),
        .addr3_valid  (addr3_valid),
        .cfg          (cfg_bus.user),
        .info         (info_bus.tracker)
    );

    filter_rules i_filter_rules (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg_bus.user),
        .info         (info_bus.rules),
        .block_rx_dma (block_rx_dma),
        .block_valid  (block_valid)
    );

endmodule

// File: dv/tb_frame_table.svh
// Frame stimulus table

typedef struct packed {
    logic [1:0]  ftype;
    logic [3:0]  subtype;
    logic [1:0]  ds;        // to/from ds bits
    logic [15:0] len;
    logic [1:0]  n_addr;    // address strobes sent
    logic [2:0]  a1;
    logic [2:0]  a2;
    logic [2:0]  a3;
    logic [13:0] flags;
    logic [8:0]  mask;
    logic        block;     // expected block_rx_dma
} row_t;

// address codes, turned into addresses by addr_of
localparam logic [2:0] a_self   = 3'd0;
localparam logic [2:0] a_ones   = 3'd1;
localparam logic [2:0] a_zeros  = 3'd2;
localparam logic [2:0] a_mcast  = 3'd3;   // 01:00:5e
localparam logic [2:0] a_mcast6 = 3'd4;   // 33:33
localparam logic [2:0] a_peer   = 3'd5;
localparam logic [2:0] a_bss    = 3'd6;
localparam logic [2:0] a_obss   = 3'd7;

localparam logic [13:0] f_none   = 14'h0000;
localparam logic [13:0] f_multi  = 14'h0002;
localparam logic [13:0] f_bcn    = 14'h0010;
localparam logic [13:0] f_ctrl   = 14'h0020;
localparam logic [13:0] f_obss   = 14'h0040;
localparam logic [13:0] f_pspoll = 14'h0080;
localparam logic [13:0] f_probe  = 14'h0100;
localparam logic [13:0] f_ucast  = 14'h0200;
localparam logic [13:0] f_ones   = 14'h0400;
localparam logic [13:0] f_zeros  = 14'h0800;
localparam logic [13:0] f_mybcn  = 14'h1000;
localparam logic [13:0] f_mon    = 14'h2000;

localparam int num_rows = 33;

// type, subtype, ds, length, strobes, addr1, addr2, addr3, flags, mask, block
localparam row_t frame_rows [0:num_rows-1] = '{
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_self, a_bss, a_peer, f_ucast, 9'h000, 1'b0},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_self, a_bss, a_peer, f_none, 9'h000, 1'b1},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_ones, a_bss, a_peer, f_ones, 9'h000, 1'b0},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_ones, a_bss, a_peer, f_ucast, 9'h000, 1'b1},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_zeros, a_bss, a_peer, f_zeros, 9'h000, 1'b0},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_zeros, a_bss, a_peer, f_ones, 9'h000, 1'b1},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_mcast, a_bss, a_peer, f_multi, 9'h000, 1'b0},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_mcast6, a_bss, a_peer, f_multi, 9'h000, 1'b0},
    // multicast allowed only through other-bss, then masked
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_mcast, a_obss, a_peer, f_obss, 9'h000, 1'b0},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_mcast, a_obss, a_peer, f_obss, 9'h002, 1'b1},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_mcast, a_bss, a_peer, f_none, 9'h000, 1'b1},
    // length checks
    '{2'd2, 4'd0, 2'b01, 16'd10, 2'd0, a_self, a_bss, a_peer, f_ucast, 9'h000, 1'b1},
    '{2'd2, 4'd0, 2'b01, 16'd300, 2'd0, a_self, a_bss, a_peer, f_ucast, 9'h1ff, 1'b1},
    '{2'd2, 4'd0, 2'b01, 16'd18, 2'd1, a_self, a_bss, a_peer, f_ucast, 9'h000, 1'b1},
    '{2'd2, 4'd0, 2'b01, 16'd24, 2'd2, a_self, a_bss, a_peer, f_ucast, 9'h1ff, 1'b1},
    '{2'd1, 4'd13, 2'b00, 16'd14, 2'd1, a_self, a_peer, a_peer, f_ctrl, 9'h020, 1'b0},
    '{2'd1, 4'd13, 2'b00, 16'd14, 2'd1, a_self, a_peer, a_peer, f_ucast, 9'h020, 1'b1},
    // beacons, bssid from addr3
    '{2'd0, 4'd8, 2'b00, 16'd60, 2'd3, a_ones, a_peer, a_bss, f_mybcn, 9'h000, 1'b0},
    '{2'd0, 4'd8, 2'b00, 16'd60, 2'd3, a_self, a_peer, a_obss, f_ucast, 9'h040, 1'b1},
    '{2'd0, 4'd8, 2'b00, 16'd60, 2'd3, a_self, a_peer, a_obss, f_ucast, 9'h000, 1'b0},
    '{2'd0, 4'd8, 2'b00, 16'd60, 2'd3, a_ones, a_peer, a_bss, f_bcn, 9'h000, 1'b0},
    // ps-poll, rts and probe request
    '{2'd1, 4'd10, 2'b00, 16'd20, 2'd2, a_self, a_peer, a_peer, f_pspoll, 9'h000, 1'b0},
    '{2'd1, 4'd10, 2'b00, 16'd20, 2'd2, a_self, a_peer, a_peer, f_ucast, 9'h080, 1'b1},
    '{2'd1, 4'd10, 2'b00, 16'd20, 2'd2, a_self, a_peer, a_peer, f_ucast, 9'h000, 1'b0},
    '{2'd1, 4'd11, 2'b00, 16'd20, 2'd2, a_self, a_peer, a_peer, f_ctrl, 9'h020, 1'b0},
    '{2'd1, 4'd11, 2'b00, 16'd20, 2'd2, a_peer, a_self, a_peer, f_ctrl, 9'h000, 1'b1},
    '{2'd1, 4'd11, 2'b00, 16'd20, 2'd2, a_self, a_peer, a_peer, f_ucast, 9'h020, 1'b1},
    '{2'd0, 4'd4, 2'b00, 16'd40, 2'd3, a_ones, a_peer, a_bss, f_probe, 9'h000, 1'b0},
    '{2'd0, 4'd4, 2'b00, 16'd40, 2'd3, a_ones, a_peer, a_bss, f_ones, 9'h100, 1'b1},
    '{2'd0, 4'd4, 2'b00, 16'd40, 2'd3, a_ones, a_peer, a_bss, f_ones, 9'h000, 1'b0},
    // monitor-all
    '{2'd2, 4'd0, 2'b01, 16'd10, 2'd0, a_self, a_bss, a_peer, f_mon, 9'h1ff, 1'b0},
    '{2'd2, 4'd0, 2'b01, 16'd60, 2'd3, a_peer, a_bss, a_peer, f_mon, 9'h000, 1'b0},
    '{2'd1, 4'd11, 2'b00, 16'd20, 2'd2, a_peer, a_self, a_peer, f_mon, 9'h1ff, 1'b0}
};

// File: dv/tb_pkt_filter.sv
// Rx frame filter testbench
`timescale 1ns/1ps

module tb_pkt_filter;
    import pkt_filter_pkg::*;

    `include "tb_frame_table.svh"

    // first octet in bits 7:0
    localparam logic [47:0] self_mac    = 48'h554433221102;
    localparam logic [47:0] self_bssid  = 48'heeddccbbaa02;
    localparam logic [47:0] other_bssid = 48'h556677889902;
    localparam logic [47:0] peer_mac    = 48'h9a7856341202;

    logic        clk;
    logic        rstn;
    logic        cfg_req;
    logic [2:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic        cfg_ack;
    logic        sig_valid;
    logic [15:0] signal_len;
    logic        ht_unsupport;
    logic [1:0]  fc_type;
    logic [3:0]  fc_subtype;
    logic [1:0]  fc_tofrom_ds;
    logic [47:0] addr1;
    logic        addr1_valid;
    logic [47:0] addr2;
    logic        addr2_valid;
    logic [47:0] addr3;
    logic        addr3_valid;
    logic        block_rx_dma;
    logic        block_valid;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    pkt_filter #(
        .max_len_reset (16'd1600)
    ) i_pkt_filter (
        .clk          (clk),
        .rstn         (rstn),
        .cfg_req      (cfg_req),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_ack      (cfg_ack),
        .sig_valid    (sig_valid),
        .signal_len   (signal_len),
        .ht_unsupport (ht_unsupport),
        .fc_type      (fc_type),
        .fc_subtype   (fc_subtype),
        .fc_tofrom_ds (fc_tofrom_ds),
        .addr1        (addr1),
        .addr1_valid  (addr1_valid),
        .addr2        (addr2),
        .addr2_valid  (addr2_valid),
        .addr3        (addr3),
        .addr3_valid  (addr3_valid),
        .block_rx_dma (block_rx_dma),
        .block_valid  (block_valid)
    );

    always #5 clk = ~clk;

    function automatic logic [47:0] addr_of(input logic [2:0] code);
        case (code)
            a_self:   return self_mac;
            a_ones:   return '1;
            a_zeros:  return '0;
            a_mcast:  return 48'hfb00005e0001;
            a_mcast6: return 48'h010000003333;
            a_peer:   return peer_mac;
            a_bss:    return self_bssid;
            default:  return other_bssid;
        endcase
    endfunction

    // gap of 0 to 3 cycles between header strobes
    function automatic int rand_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("mismatch at %0d ns: %s, got %0d expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic drop_strobes();
        sig_valid   = 1'b0;
        addr1_valid = 1'b0;
        addr2_valid = 1'b0;
        addr3_valid = 1'b0;
    endtask

    task automatic gap_after_strobe();
        int gap;
        @(posedge clk);
        #1;
        drop_strobes();
        gap = rand_gap();
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // four-phase write, ack expected one cycle after each req edge
    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        int cycles;
        check(32'(cfg_ack), 32'd0, "cfg_ack high before req");
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_req   = 1'b1;
        cycles    = 0;
        while (!cfg_ack && cycles < 8)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        check(cycles, 1, "cycles from req rise to ack rise");
        cfg_req = 1'b0;
        cycles  = 0;
        while (cfg_ack && cycles < 8)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        check(cycles, 1, "cycles from req fall to ack fall");
    endtask

    task automatic send_frame(input int idx, input row_t r);
        int lat;
        fc_type      = r.ftype;
        fc_subtype   = r.subtype;
        fc_tofrom_ds = r.ds;
        addr1        = addr_of(r.a1);
        addr2        = addr_of(r.a2);
        addr3        = addr_of(r.a3);
        signal_len   = r.len;
        sig_valid    = 1'b1;
        if (r.n_addr > 2'd0)
        begin
            gap_after_strobe();
            addr1_valid = 1'b1;
        end
        if (r.n_addr > 2'd1)
        begin
            gap_after_strobe();
            addr2_valid = 1'b1;
        end
        if (r.n_addr > 2'd2)
        begin
            gap_after_strobe();
            addr3_valid = 1'b1;
        end
        lat = 0;    // edges since the last strobe was driven
        while (!block_valid && lat < 8)
        begin
            @(posedge clk);
            #1;
            drop_strobes();
            lat++;
        end
        if (!block_valid)
        begin
            errors++;
            $display("no block_valid from the DUT for row %0d", idx);
        end
        else
        begin
            check(lat, 2, $sformatf("row %0d cycles to block_valid", idx));
            check(32'(block_rx_dma), 32'(r.block), $sformatf("row %0d block_rx_dma", idx));
            @(posedge clk);
            #1;
            check(32'(block_valid), 32'd0, $sformatf("row %0d block_valid width", idx));
        end
    endtask

    // a full header with ht_unsupport set must give no decision
    task automatic check_ht_skip();
        int seen;
        seen         = 0;
        fc_type      = 2'd2;
        fc_subtype   = 4'd0;
        fc_tofrom_ds = 2'b01;
        addr1        = self_mac;
        addr2        = self_bssid;
        addr3        = peer_mac;
        signal_len   = 16'd60;
        ht_unsupport = 1'b1;
        sig_valid    = 1'b1;
        for (int k = 1; k <= 8; k++)
        begin
            @(posedge clk);
            #1;
            drop_strobes();
            ht_unsupport = 1'b0;
            addr1_valid  = (k == 1);
            addr2_valid  = (k == 2);
            addr3_valid  = (k == 3);
            if (block_valid)
                seen++;
        end
        check(seen, 0, "block_valid pulses for an ht_unsupport frame");
    endtask

    initial
    begin
        repeat (num_rows * 40 + 200) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", num_rows * 40 + 200);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        clk          = 1'b0;
        rstn         = 1'b0;
        cfg_req      = 1'b0;
        cfg_addr     = 3'd0;
        cfg_wdata    = 32'd0;
        ht_unsupport = 1'b0;
        signal_len   = 16'd0;
        fc_type      = 2'd0;
        fc_subtype   = 4'd0;
        fc_tofrom_ds = 2'd0;
        addr1        = '0;
        addr2        = '0;
        addr3        = '0;
        drop_strobes();
        errors    = 0;
        checks    = 0;
        lcg_state = 32'd54526;

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        check(32'(cfg_ack), 32'd0, "cfg_ack after reset");
        check(32'(block_valid), 32'd0, "block_valid after reset");

        write_reg(reg_max_len, 32'd200);
        write_reg(reg_mac_lo, self_mac[31:0]);
        write_reg(reg_mac_hi, {16'd0, self_mac[47:32]});
        write_reg(reg_bssid_lo, self_bssid[31:0]);
        write_reg(reg_bssid_hi, {16'd0, self_bssid[47:32]});
        write_reg(3'd7, 32'hffffffff);     // unmapped
        check_ht_skip();

        for (int i = 0; i < num_rows; i++)
        begin
            write_reg(reg_filter_cfg, {18'd0, frame_rows[i].flags});
            write_reg(reg_discard_mask, {23'd0, frame_rows[i].mask});
            send_frame(i, frame_rows[i]);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+dv
source/pkt_filter_pkg.sv
source/filter_cfg_if.sv
source/frame_info_if.sv
source/filter_cfg_regs.sv
source/header_tracker.sv
source/filter_rules.sv
source/pkt_filter.sv
dv/tb_pkt_filter.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_pkt_filter -o sim_pkt_filter

output=$(./obj_dir/sim_pkt_filter)
echo "$output"

if grep -qx "Everything OK" <<< "$output"
then
    exit 0
fi
exit 1
